//--- design/csr_rs_pkg.sv
package csr_rs_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // station sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int rs_depth = 8;
  localparam int rs_idx_w = 3;
  localparam int tag_w    = 8;
  localparam int n_wb     = 7;

  // micro-op as it arrives from dispatch
  typedef struct packed {
    logic [31:0]      inst_num;
    logic [tag_w-1:0] rd;
    logic [3:0]       op;
    logic [tag_w-1:0] src_tag;
    logic             src_ready;
    logic             use_imm;
    logic [11:0]      csr_addr;
    logic [31:0]      csr_data;
    logic [31:0]      imm;
  } csr_uop_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } wb_t;

  // index order is alu, mul, div, mem, br, p, csr
  typedef wb_t [n_wb-1:0] wb_bus_t;

  // the slot index takes the place of src_ready once the entry leaves
  typedef struct packed {
    logic [31:0]         inst_num;
    logic [tag_w-1:0]    rd;
    logic [3:0]          op;
    logic [tag_w-1:0]    src_tag;
    logic [rs_idx_w-1:0] slot_idx;
    logic                use_imm;
    logic [11:0]         csr_addr;
    logic [31:0]         csr_data;
    logic [31:0]         imm;
  } csr_issue_t;

  // true when any valid broadcast this cycle carries the given tag
  function automatic logic wb_hit(wb_bus_t bus, logic [tag_w-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < n_wb; s++) begin
      hit = hit | (bus[s].valid && (bus[s].tag == tag));
    end
    return hit;
  endfunction

endpackage

//--- design/rs_slot_alloc.sv
`timescale 1ns/1ns

module rs_slot_alloc import csr_rs_pkg::*; (
  input  logic [rs_depth-1:0] entry_valid,
  output logic [rs_idx_w-1:0] alloc_idx,
  output logic                full
);

  logic found;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lowest free slot
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // scan from the top down so the last hit is the lowest index
  always_comb begin
    alloc_idx = '0;
    found     = 1'b0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!entry_valid[i]) begin
        alloc_idx = rs_idx_w'(i);
        found     = 1'b1;
      end
    end
  end

  // with no clear bit the index above is meaningless and the array
  // must not write
  assign full = !found;

endmodule

//--- design/rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select import csr_rs_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic [rs_depth-1:0]           entry_valid,
  input  logic [rs_depth-1:0]           entry_ready,
  input  csr_uop_t [rs_depth-1:0]       entries,
  output logic                          free_valid,
  output logic [rs_idx_w-1:0]           free_idx,
  output logic                          issue_valid,
  output csr_issue_t                    issue_uop
);

  logic [rs_depth-1:0] cand;
  logic [rs_idx_w-1:0] sel_idx;
  csr_uop_t            sel_uop;

  assign cand = entry_valid & entry_ready;

  // lowest ready slot wins, there is no other age ordering
  always_comb begin
    sel_idx = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel_idx = rs_idx_w'(i);
      end
    end
  end

  assign sel_uop    = entries[sel_idx];
  assign free_valid = (|cand) && !flush;
  assign free_idx   = sel_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // issue register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= free_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (free_valid) begin
      issue_uop.inst_num <= sel_uop.inst_num;
      issue_uop.rd       <= sel_uop.rd;
      issue_uop.op       <= sel_uop.op;
      issue_uop.src_tag  <= sel_uop.src_tag;
      issue_uop.slot_idx <= sel_idx;
      issue_uop.use_imm  <= sel_uop.use_imm;
      issue_uop.csr_addr <= sel_uop.csr_addr;
      issue_uop.csr_data <= sel_uop.csr_data;
      issue_uop.imm      <= sel_uop.imm;
    end
  end

endmodule

//--- design/rs_entry_array.sv
`timescale 1ns/1ns

module rs_entry_array import csr_rs_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    dispatch_valid,
  input  csr_uop_t                dispatch_uop,
  input  logic [rs_idx_w-1:0]     alloc_idx,
  input  logic                    full,
  input  wb_bus_t                 wb,
  input  logic                    free_valid,
  input  logic [rs_idx_w-1:0]     free_idx,
  output logic [rs_depth-1:0]     entry_valid,
  output logic [rs_depth-1:0]     entry_ready,
  output csr_uop_t [rs_depth-1:0] entries
);

  logic [rs_depth-1:0]     valid_q;
  logic [rs_depth-1:0]     ready_q;
  logic [rs_depth-1:0]     wake;
  csr_uop_t [rs_depth-1:0] payload_q;
  logic                    do_write;
  logic                    dispatch_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // dispatch and wakeup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a dispatch while full is dropped, upstream is expected to hold off
  assign do_write = dispatch_valid && !full;

  // a broadcast in the dispatch cycle itself also counts, otherwise the
  // entry would miss it and wait forever
  assign dispatch_ready = dispatch_uop.src_ready || wb_hit(wb, dispatch_uop.src_tag);

  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      wake[i] = valid_q[i] && !ready_q[i] && wb_hit(wb, payload_q[i].src_tag);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the freed slot is always valid and the allocated one never is, so the
  // two writes below never land on the same index
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q <= '0;
    end else begin
      if (free_valid) begin
        valid_q[free_idx] <= 1'b0;
      end
      if (do_write) begin
        valid_q[alloc_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ready_q <= '0;
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        if (wake[i]) begin
          ready_q[i] <= 1'b1;
        end
      end
      if (free_valid) begin
        ready_q[free_idx] <= 1'b0;
      end
      if (do_write) begin
        ready_q[alloc_idx] <= dispatch_ready;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (do_write) begin
      payload_q[alloc_idx] <= dispatch_uop;
    end
  end

  assign entries     = payload_q;
  assign entry_valid = valid_q;
  assign entry_ready = ready_q;

endmodule

//--- design/csr_rs_top.sv
`timescale 1ns/1ns

module csr_rs_top import csr_rs_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       dispatch_valid,
  input  csr_uop_t   dispatch_uop,
  input  wb_bus_t    wb,
  output logic       issue_valid,
  output csr_issue_t issue_uop,
  output logic       full
);

  logic [rs_depth-1:0]     entry_valid;
  logic [rs_depth-1:0]     entry_ready;
  csr_uop_t [rs_depth-1:0] entries;
  logic [rs_idx_w-1:0]     alloc_idx;
  logic                    free_valid;
  logic [rs_idx_w-1:0]     free_idx;

  rs_slot_alloc u_alloc (
    .entry_valid (entry_valid),
    .alloc_idx   (alloc_idx),
    .full        (full)
  );

  rs_entry_array u_array (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_uop   (dispatch_uop),
    .alloc_idx      (alloc_idx),
    .full           (full),
    .wb             (wb),
    .free_valid     (free_valid),
    .free_idx       (free_idx),
    .entry_valid    (entry_valid),
    .entry_ready    (entry_ready),
    .entries        (entries)
  );

  // one issue per cycle, the CSR unit has no way to stall it
  rs_issue_select u_select (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .entry_valid (entry_valid),
    .entry_ready (entry_ready),
    .entries     (entries),
    .free_valid  (free_valid),
    .free_idx    (free_idx),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop)
  );

endmodule

//--- verification/csr_rs_sva.sv
`timescale 1ns/1ns

module csr_rs_sva (
  input logic clk,
  input logic reset,
  input logic flush,
  input logic dispatch_valid,
  input logic full,
  input logic issue_valid
);

  int unsigned fail_count = 0;
  logic        disp_seen;
  logic        disp_seen_q;

  // disp_seen_q rises two cycles after the first dispatch since reset
  always_ff @(posedge clk) begin
    if (reset) begin
      disp_seen   <= 1'b0;
      disp_seen_q <= 1'b0;
    end else begin
      disp_seen   <= disp_seen || dispatch_valid;
      disp_seen_q <= disp_seen;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_idle_after_clear: assert property (@(posedge clk) (reset || flush) |=> !issue_valid)
    else begin
      fail_count++;
      $error("issue_valid high in the cycle after reset or flush");
    end

  a_no_dispatch_full: assert property (@(posedge clk) disable iff (reset)
                                       !(dispatch_valid && full))
    else begin
      fail_count++;
      $error("dispatch while the station is full");
    end

  a_issue_latency: assert property (@(posedge clk) disable iff (reset)
                                    issue_valid |-> disp_seen_q)
    else begin
      fail_count++;
      $error("issue earlier than two cycles after the first dispatch");
    end

endmodule

bind csr_rs_top csr_rs_sva sva_i (
  .clk            (clk),
  .reset          (reset),
  .flush          (flush),
  .dispatch_valid (dispatch_valid),
  .full           (full),
  .issue_valid    (issue_valid)
);

//--- verification/csr_rs_tb.sv
`timescale 1ns/1ns

module csr_rs_tb import csr_rs_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 4;
  localparam int n_cycles     = 2000;
  localparam int watchdog_ns  = (n_cycles + reset_cycles + 50) * clk_period;

  logic       clk = 1'b0;
  logic       reset;
  logic       flush;
  logic       dispatch_valid;
  csr_uop_t   dispatch_uop;
  wb_bus_t    wb;
  logic       issue_valid;
  csr_issue_t issue_uop;
  logic       full;

  // reference model of the station
  logic [rs_depth-1:0] m_valid;
  logic [rs_depth-1:0] m_ready;
  csr_uop_t            m_uop [rs_depth];
  logic                exp_issue_valid;
  csr_issue_t          exp_issue_uop;
  logic                exp_full;
  logic [31:0]         inst_count;

  always #(clk_period / 2) clk = ~clk;

  csr_rs_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_uop   (dispatch_uop),
    .wb             (wb),
    .issue_valid    (issue_valid),
    .issue_uop      (issue_uop),
    .full           (full)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic tag_seen(wb_bus_t bus, logic [tag_w-1:0] tag);
    for (int s = 0; s < n_wb; s++) begin
      if (bus[s].valid && bus[s].tag == tag) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // called at the rising edge, before the inputs driven there take effect
  task automatic model_step();
    logic [rs_depth-1:0] n_valid;
    logic [rs_depth-1:0] n_ready;
    int                  sel;
    int                  slot;
    if (reset || flush) begin
      m_valid         = '0;
      m_ready         = '0;
      exp_issue_valid = 1'b0;
    end else begin
      n_valid = m_valid;
      n_ready = m_ready;
      sel     = -1;
      slot    = -1;
      for (int i = rs_depth - 1; i >= 0; i--) begin
        if (m_valid[i] && m_ready[i]) sel = i;
        if (!m_valid[i]) slot = i;
        if (m_valid[i] && !m_ready[i] && tag_seen(wb, m_uop[i].src_tag)) n_ready[i] = 1'b1;
      end
      exp_issue_valid = (sel >= 0);
      if (sel >= 0) begin
        n_valid[sel]           = 1'b0;
        n_ready[sel]           = 1'b0;
        exp_issue_uop.inst_num = m_uop[sel].inst_num;
        exp_issue_uop.rd       = m_uop[sel].rd;
        exp_issue_uop.op       = m_uop[sel].op;
        exp_issue_uop.src_tag  = m_uop[sel].src_tag;
        exp_issue_uop.slot_idx = rs_idx_w'(sel);
        exp_issue_uop.use_imm  = m_uop[sel].use_imm;
        exp_issue_uop.csr_addr = m_uop[sel].csr_addr;
        exp_issue_uop.csr_data = m_uop[sel].csr_data;
        exp_issue_uop.imm      = m_uop[sel].imm;
      end
      // a dispatch into a full station is dropped
      if (dispatch_valid && slot >= 0) begin
        n_valid[slot] = 1'b1;
        n_ready[slot] = dispatch_uop.src_ready || tag_seen(wb, dispatch_uop.src_tag);
        m_uop[slot]   = dispatch_uop;
      end
      m_valid = n_valid;
      m_ready = n_ready;
    end
    exp_full = &m_valid;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // tags come from a narrow range so wakeups hit often
  task automatic drive_inputs();
    csr_uop_t uop;
    wb_bus_t  bus;
    logic     go;
    go           = !exp_full && ($urandom_range(99) < 60);
    uop.inst_num = inst_count;
    uop.rd       = 8'($urandom);
    uop.op       = 4'($urandom_range(15));
    uop.src_tag  = 8'($urandom_range(15));
    uop.src_ready = ($urandom_range(2) == 0);
    uop.use_imm  = 1'($urandom_range(1));
    uop.csr_addr = 12'($urandom);
    uop.csr_data = $urandom;
    uop.imm      = $urandom;
    for (int s = 0; s < n_wb; s++) begin
      bus[s].valid = ($urandom_range(5) == 0);
      bus[s].tag   = 8'($urandom_range(15));
    end
    dispatch_valid <= go;
    dispatch_uop   <= uop;
    wb             <= bus;
    flush          <= ($urandom_range(199) == 0);
    if (go) inst_count = inst_count + 1;
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_issue(input logic act_valid, input csr_issue_t act_uop);
    if (act_valid !== exp_issue_valid) begin
      stop_run($sformatf("error: %0t ns: issue_valid is %b, expected %b",
                         $time, act_valid, exp_issue_valid));
    end else if (exp_issue_valid && act_uop !== exp_issue_uop) begin
      stop_run($sformatf("error: %0t ns: issued inst %0d slot %0d, expected inst %0d slot %0d",
                         $time, act_uop.inst_num, act_uop.slot_idx,
                         exp_issue_uop.inst_num, exp_issue_uop.slot_idx));
    end
  endtask

  task automatic check_full(input logic act_full);
    if (act_full !== exp_full) begin
      stop_run($sformatf("error: %0t ns: full is %b, expected %b", $time, act_full, exp_full));
    end
  endtask

  initial begin
    void'($urandom(32'h93da));
    reset          = 1'b1;
    flush          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_uop   = '0;
    wb             = '0;
    inst_count     = '0;
    for (int cyc = 0; cyc < reset_cycles + n_cycles; cyc++) begin
      @(posedge clk);
      model_step();
      if (cyc == reset_cycles - 1) reset <= 1'b0;
      if (cyc >= reset_cycles - 1) drive_inputs();
      @(negedge clk);
      check_issue(issue_valid, issue_uop);
      check_full(full);
      if (dut_i.sva_i.fail_count != 0) begin
        stop_run("a bound protocol assertion failed");
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    stop_run("timeout: the test loop did not finish in the expected time");
  end

endmodule

//--- tb.f
design/csr_rs_pkg.sv
design/rs_slot_alloc.sv
design/rs_issue_select.sv
design/rs_entry_array.sv
design/csr_rs_top.sv
verification/csr_rs_sva.sv
verification/csr_rs_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Mdir obj_dir
TOP       := csr_rs_tb
FILELIST  := tb.f
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the pipe
run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
